// ==== Makefile ====
# Verilator build, run and lint for the rename slice
TOP := rename_top_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): rename_top.f $(wildcard logic/*.sv logic/*.svh tests/*.sv)
	verilator --binary --timing --assert -f rename_top.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f rename_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== logic/cdb_arbiter.sv ====
/*
  cdb arbiter
  fixed priority, lowest unit wins, granted result driven onto the bus
*/
`default_nettype none
`timescale 1ns/1ns

`include "rename_config.svh"

module cdb_arbiter import rename_pkg::*; (
  input  logic [`NUM_FU-1:0] fu_valid,
  input  cdb_t [`NUM_FU-1:0] fu_result,
  output logic [`NUM_FU-1:0] fu_ready,
  output logic               cdb_valid,
  output cdb_t               cdb
);

  logic [`NUM_FU-1:0] grant;    // one-hot or zero
  logic               found;    // higher priority unit already granted

  always_comb begin
    grant = '0;
    found = 1'b0;
    for (int i = 0; i < `NUM_FU; i++) begin
      if (fu_valid[i] && !found) begin
        grant[i] = 1'b1;
        found    = 1'b1;
      end
    end
  end

  // and-or mux, grant is one-hot
  always_comb begin
    cdb = '0;
    for (int i = 0; i < `NUM_FU; i++) begin
      if (grant[i]) begin
        cdb = fu_result[i];
      end
    end
  end

  assign fu_ready  = grant;        // losers hold their request
  assign cdb_valid = |fu_valid;    // any request wins someone

endmodule

`default_nettype wire

// ==== logic/free_list.sv ====
/*
  free list
  circular queue of unused physical tags, pop on alloc, push on release
*/
`default_nettype none
`timescale 1ns/1ns

`include "rename_config.svh"

module free_list import rename_pkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  logic    alloc,
  output pr_tag_t head_tag,
  output logic    empty,
  input  logic    release_valid,
  input  pr_tag_t release_tag
);

  // tags 1..NUM_PR-2 circulate, NUM_AR-1 of them always mapped
  localparam int DEPTH = `NUM_PR - `NUM_AR;
  localparam int INIT  = `NUM_PR - 1 - `NUM_AR;    // tags NUM_AR..NUM_PR-2
  localparam int PW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);

  pr_tag_t         queue [DEPTH];
  logic [PW-1:0]   head;       // next tag to hand out
  logic [PW-1:0]   tail;       // next free slot
  logic [CW-1:0]   count;
  logic            push;
  logic            pop;

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty    = (count == '0);
  assign head_tag = queue[head];

  assign pop  = alloc && !empty;    // never pop an empty queue
  assign push = release_valid && (release_tag != pr_tag_t'(`ZERO_PR));    // zero tag dropped

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        queue[i] <= (i < INIT) ? pr_tag_t'(`NUM_AR + i) : '0;
      end
      head  <= '0;
      tail  <= PW'(INIT);
      count <= CW'(INIT);
    end else begin
      if (push) begin
        queue[tail] <= release_tag;
        tail        <= next_ptr(tail);
      end
      if (pop) begin
        head <= next_ptr(head);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;    // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/map_table.sv ====
/*
  map table
  architectural to physical tag mapping, lookup and rename update
*/
`default_nettype none
`timescale 1ns/1ns

`include "rename_config.svh"

module map_table import rename_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  rename_req_t rename_req,
  input  logic        rename_fire,
  input  pr_tag_t     new_tag,
  output pr_tag_t     t1_idx,
  output pr_tag_t     t2_idx,
  output pr_tag_t     told_idx
);

  pr_tag_t map [`NUM_AR];    // current tag per arch reg
  logic    do_write;         // accepted rename with a dest

  // lookups see the table before this cycle's update
  assign t1_idx   = map[rename_req.src1_ar];
  assign t2_idx   = map[rename_req.src2_ar];
  assign told_idx = map[rename_req.dest_ar];    // zero tag when dest_ar is 0

  assign do_write = rename_fire && (rename_req.dest_ar != '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      map[0] <= pr_tag_t'(`ZERO_PR);    // arch 0 bound to zero reg
      for (int i = 1; i < `NUM_AR; i++) begin
        map[i] <= pr_tag_t'(i);         // identity mapping out of reset
      end
    end else if (do_write) begin
      map[rename_req.dest_ar] <= new_tag;    // visible next cycle
    end
  end

endmodule

`default_nettype wire

// ==== logic/phys_regfile.sv ====
/*
  physical register file
  cdb write-back and per-unit operand reads with bus forwarding
*/
`default_nettype none
`timescale 1ns/1ns

`include "rename_config.svh"

module phys_regfile import rename_pkg::*; (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       cdb_valid,
  input  cdb_t                       cdb,
  input  fu_read_t     [`NUM_FU-1:0] fu_read,
  output fu_operands_t [`NUM_FU-1:0] operands
);

  reg_value_t regs [`NUM_PR];
  logic       wr_en;    // bus word lands this edge

  // zero reg is never written
  assign wr_en = cdb_valid && (cdb.t_idx != pr_tag_t'(`ZERO_PR));

  // zero tag first, then same cycle bus value, then storage
  function automatic reg_value_t read_tag(
    input pr_tag_t    tag,
    input logic       fwd_en,
    input cdb_t       bus
  );
    if (tag == pr_tag_t'(`ZERO_PR)) begin
      return '0;
    end
    if (fwd_en && (bus.t_idx == tag)) begin
      return bus.t_value;    // forwarding
    end
    return regs[tag];
  endfunction

  always_comb begin
    for (int i = 0; i < `NUM_FU; i++) begin
      operands[i].t1_value = read_tag(fu_read[i].t1_idx, wr_en, cdb);
      operands[i].t2_value = read_tag(fu_read[i].t2_idx, wr_en, cdb);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_PR; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[cdb.t_idx] <= cdb.t_value;    // complete stage write-back
    end
  end

endmodule

`default_nettype wire

// ==== logic/rename_config.svh ====
/*
  rename slice configuration
  register counts, data width and the hard-wired zero tag
*/
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// physical register file size, tag width follows from it
`define NUM_PR 32

// architectural registers, entry 0 is the zero register
`define NUM_AR 16

`define NUM_FU 2         // units sharing the cdb
`define XLEN 64          // data word width

// physical reg that always reads zero
`define ZERO_PR 31

`endif

// ==== logic/rename_pkg.sv ====
/*
  rename package
  tag, value and bundle types shared across the rename slice
*/
`default_nettype none

`include "rename_config.svh"

package rename_pkg;

  typedef logic [$clog2(`NUM_PR)-1:0] pr_tag_t;    // physical tag
  typedef logic [$clog2(`NUM_AR)-1:0] ar_idx_t;    // architectural index
  typedef logic [`XLEN-1:0] reg_value_t;           // data word

  // one rename request, dest_ar 0 = no destination
  typedef struct packed {
    ar_idx_t dest_ar;
    ar_idx_t src1_ar;
    ar_idx_t src2_ar;
  } rename_req_t;

  typedef struct packed {
    pr_tag_t t_idx;       // newly allocated dest tag
    pr_tag_t t1_idx;      // source tags before update
    pr_tag_t t2_idx;
    pr_tag_t told_idx;    // displaced dest mapping
  } rename_rsp_t;

  // completion from a unit, also the bus word
  typedef struct packed {
    pr_tag_t    t_idx;
    reg_value_t t_value;
  } cdb_t;

  typedef struct packed {
    pr_tag_t t1_idx;
    pr_tag_t t2_idx;
  } fu_read_t;

  typedef struct packed {
    reg_value_t t1_value;
    reg_value_t t2_value;
  } fu_operands_t;

endpackage

`default_nettype wire

// ==== logic/rename_top.sv ====
/*
  rename slice top
  joins map table, free list, cdb arbiter and physical register file
*/
`default_nettype none
`timescale 1ns/1ns

`include "rename_config.svh"

module rename_top import rename_pkg::*; (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       rename_valid,
  input  rename_req_t                rename_req,
  output logic                       rename_ready,
  output rename_rsp_t                rename_rsp,
  input  logic                       retire_valid,
  input  pr_tag_t                    retire_idx,
  input  logic         [`NUM_FU-1:0] fu_valid,
  input  cdb_t         [`NUM_FU-1:0] fu_result,
  output logic         [`NUM_FU-1:0] fu_ready,
  input  fu_read_t     [`NUM_FU-1:0] fu_read,
  output fu_operands_t [`NUM_FU-1:0] operands
);

  logic    has_dest;       // request writes a register
  logic    fl_empty;
  logic    rename_fire;    // handshake this edge
  logic    alloc;
  pr_tag_t head_tag;
  logic    cdb_valid;
  cdb_t    cdb;

  assign has_dest     = (rename_req.dest_ar != '0);
  assign rename_ready = !(has_dest && fl_empty);    // stall only when a tag is needed
  assign rename_fire  = rename_valid && rename_ready;
  assign alloc        = rename_fire && has_dest;

  assign rename_rsp.t_idx = has_dest ? head_tag : pr_tag_t'(`ZERO_PR);

  map_table u_map_table (
    .clock       (clock),
    .reset       (reset),
    .rename_req  (rename_req),
    .rename_fire (rename_fire),
    .new_tag     (head_tag),
    .t1_idx      (rename_rsp.t1_idx),
    .t2_idx      (rename_rsp.t2_idx),
    .told_idx    (rename_rsp.told_idx)    // zero tag for arch 0
  );

  free_list u_free_list (
    .clock         (clock),
    .reset         (reset),
    .alloc         (alloc),
    .head_tag      (head_tag),
    .empty         (fl_empty),
    .release_valid (retire_valid),
    .release_tag   (retire_idx)
  );

  cdb_arbiter u_cdb_arbiter (
    .fu_valid  (fu_valid),
    .fu_result (fu_result),
    .fu_ready  (fu_ready),
    .cdb_valid (cdb_valid),
    .cdb       (cdb)
  );

  phys_regfile u_phys_regfile (
    .clock     (clock),
    .reset     (reset),
    .cdb_valid (cdb_valid),
    .cdb       (cdb),
    .fu_read   (fu_read),
    .operands  (operands)
  );

endmodule

`default_nettype wire

// ==== rename_top.f ====
+incdir+logic
logic/rename_pkg.sv
logic/map_table.sv
logic/free_list.sv
logic/cdb_arbiter.sv
logic/phys_regfile.sv
logic/rename_top.sv
tests/rename_top_props.sv
tests/rename_top_tb.sv

// ==== tests/rename_top_props.sv ====
/*
  rename slice properties
  rename stall, one-hot cdb grant and zero register reads
*/
`default_nettype none
`timescale 1ns/1ns

`include "rename_config.svh"

module rename_top_props import rename_pkg::*; (
  input logic                       clock,
  input logic                       reset,
  input logic                       rename_valid,
  input rename_req_t                rename_req,
  input logic                       rename_ready,
  input rename_rsp_t                rename_rsp,
  input logic         [`NUM_FU-1:0] fu_valid,
  input logic         [`NUM_FU-1:0] fu_ready,
  input fu_read_t     [`NUM_FU-1:0] fu_read,
  input fu_operands_t [`NUM_FU-1:0] operands
);

  // stalled request held one more cycle sees an unchanged map
  a_no_stall_fire: assert property (@(posedge clock) disable iff (reset)
    (rename_valid && !rename_ready) ##1 (rename_valid && $stable(rename_req))
      |-> ($stable(rename_rsp.t1_idx) && $stable(rename_rsp.t2_idx) &&
           $stable(rename_rsp.told_idx)))
    else $error("map changed while a rename was stalled");

  a_grant_onehot: assert property (@(posedge clock) disable iff (reset)
    $onehot0(fu_ready) && ((fu_ready & ~fu_valid) == '0))    // only a requester
    else $error("cdb grant not one-hot or given to an idle unit");

  for (genvar i = 0; i < `NUM_FU; i++) begin : g_zero_read
    a_zero_t1: assert property (@(posedge clock) disable iff (reset)
      (fu_read[i].t1_idx == pr_tag_t'(`ZERO_PR)) |-> (operands[i].t1_value == '0))
      else $error("zero register read nonzero on unit %0d source 1", i);
    a_zero_t2: assert property (@(posedge clock) disable iff (reset)
      (fu_read[i].t2_idx == pr_tag_t'(`ZERO_PR)) |-> (operands[i].t2_value == '0))
      else $error("zero register read nonzero on unit %0d source 2", i);
  end

endmodule

bind rename_top rename_top_props u_props (
  .clock        (clock),
  .reset        (reset),
  .rename_valid (rename_valid),
  .rename_req   (rename_req),
  .rename_ready (rename_ready),
  .rename_rsp   (rename_rsp),
  .fu_valid     (fu_valid),
  .fu_ready     (fu_ready),
  .fu_read      (fu_read),
  .operands     (operands)
);

`default_nettype wire

// ==== tests/rename_top_tb.sv ====
/*
  rename slice testbench
  random stimulus checked against a model of map, free list and registers
*/
`default_nettype none
`timescale 1ns/1ns

`include "rename_config.svh"

module rename_top_tb import rename_pkg::*; ();

  localparam int NUM_CYCLES = 2000;
  localparam int TIMEOUT    = NUM_CYCLES + 100;
  localparam pr_tag_t ZERO_TAG = pr_tag_t'(`ZERO_PR);

  logic                       clock;
  logic                       reset;
  logic                       rename_valid;
  rename_req_t                rename_req;
  logic                       rename_ready;
  rename_rsp_t                rename_rsp;
  logic                       retire_valid;
  pr_tag_t                    retire_idx;
  logic         [`NUM_FU-1:0] fu_valid;
  cdb_t         [`NUM_FU-1:0] fu_result;
  logic         [`NUM_FU-1:0] fu_ready;
  fu_read_t     [`NUM_FU-1:0] fu_read;
  fu_operands_t [`NUM_FU-1:0] operands;

  pr_tag_t    model_map [`NUM_AR];    // arch to phys
  reg_value_t model_regs [`NUM_PR];
  pr_tag_t    free_q [$];             // free tags with head at front
  pr_tag_t    told_q [$];             // displaced tags awaiting retire

  integer             seed;
  int                 errors;
  int                 checks;
  int                 cycles = 0;
  logic               exp_ready;      // model view of this cycle
  logic [`NUM_FU-1:0] exp_grant;
  logic               bus_wr;
  cdb_t               bus;
  logic               rename_hold;    // stalled request kept next cycle
  logic [`NUM_FU-1:0] fu_hold;        // losing units keep their request

  rename_top DUT (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout after %0d cycles, run did not complete", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors++;
    $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
  endtask

  task automatic init_model();
    model_map[0] = ZERO_TAG;
    for (int i = 1; i < `NUM_AR; i++) begin
      model_map[i] = pr_tag_t'(i);
    end
    free_q.delete();
    told_q.delete();
    for (int t = `NUM_AR; t < `ZERO_PR; t++) begin
      free_q.push_back(pr_tag_t'(t));    // 16..30 in order
    end
    for (int r = 0; r < `NUM_PR; r++) begin
      model_regs[r] = '0;
    end
  endtask

  // zero tag beats bus word beats stored value
  function automatic reg_value_t model_read(input pr_tag_t tag);
    if (tag == ZERO_TAG) begin
      return '0;
    end
    if (bus_wr && (bus.t_idx == tag)) begin
      return bus.t_value;
    end
    return model_regs[tag];
  endfunction

  task automatic drive_inputs();
    logic [31:0] rnd;
    rnd = $random(seed);
    if (!rename_hold) begin
      rename_valid <= (({$random(seed)} % 10) < 6);
      rename_req   <= rnd[11:0];
    end
    if ((told_q.size() > 0) && (({$random(seed)} % 10) < 3)) begin
      retire_valid <= 1'b1;
      retire_idx   <= told_q.pop_front();    // retire in told order
    end else begin
      retire_valid <= 1'b0;
    end
    for (int i = 0; i < `NUM_FU; i++) begin
      if (!fu_hold[i]) begin
        rnd = $random(seed);
        fu_valid[i]          <= (({$random(seed)} % 10) < 4);
        fu_result[i].t_idx   <= rnd[4:0];    // 31 included
        fu_result[i].t_value <= {$random(seed), $random(seed)};
      end
      rnd = $random(seed);
      fu_read[i] <= rnd[9:0];
    end
  endtask

  task automatic check_outputs();
    reg_value_t exp_val;
    pr_tag_t    exp_tag;
    checks++;
    exp_ready = !((rename_req.dest_ar != '0) && (free_q.size() == 0));
    if (rename_ready !== exp_ready) begin
      report_mismatch("rename_ready", 64'(rename_ready), 64'(exp_ready));
    end
    if (rename_valid) begin
      if (rename_rsp.t1_idx !== model_map[rename_req.src1_ar]) begin
        report_mismatch("t1_idx", 64'(rename_rsp.t1_idx), 64'(model_map[rename_req.src1_ar]));
      end
      if (rename_rsp.t2_idx !== model_map[rename_req.src2_ar]) begin
        report_mismatch("t2_idx", 64'(rename_rsp.t2_idx), 64'(model_map[rename_req.src2_ar]));
      end
      if (rename_rsp.told_idx !== model_map[rename_req.dest_ar]) begin
        report_mismatch("told_idx", 64'(rename_rsp.told_idx),
                        64'(model_map[rename_req.dest_ar]));
      end
      if (exp_ready) begin    // head undefined while stalled
        exp_tag = (rename_req.dest_ar != '0) ? free_q[0] : ZERO_TAG;
        if (rename_rsp.t_idx !== exp_tag) begin
          report_mismatch("t_idx", 64'(rename_rsp.t_idx), 64'(exp_tag));
        end
      end
    end
    exp_grant = '0;
    bus       = '0;
    for (int i = `NUM_FU - 1; i >= 0; i--) begin    // lowest valid unit wins
      if (fu_valid[i]) begin
        exp_grant    = '0;
        exp_grant[i] = 1'b1;
        bus          = fu_result[i];
      end
    end
    bus_wr = (|fu_valid) && (bus.t_idx != ZERO_TAG);
    if (fu_ready !== exp_grant) begin
      report_mismatch("fu_ready", 64'(fu_ready), 64'(exp_grant));
    end
    for (int i = 0; i < `NUM_FU; i++) begin
      exp_val = model_read(fu_read[i].t1_idx);
      if (operands[i].t1_value !== exp_val) begin
        report_mismatch($sformatf("operands[%0d].t1_value", i), operands[i].t1_value, exp_val);
      end
      exp_val = model_read(fu_read[i].t2_idx);
      if (operands[i].t2_value !== exp_val) begin
        report_mismatch($sformatf("operands[%0d].t2_value", i), operands[i].t2_value, exp_val);
      end
    end
  endtask

  // state as it will stand after the coming edge
  task automatic update_model();
    if (rename_valid && exp_ready && (rename_req.dest_ar != '0)) begin
      told_q.push_back(model_map[rename_req.dest_ar]);
      model_map[rename_req.dest_ar] = free_q.pop_front();
    end
    if (retire_valid && (retire_idx != ZERO_TAG)) begin
      free_q.push_back(retire_idx);    // usable from next cycle
    end
    if (bus_wr) begin
      model_regs[bus.t_idx] = bus.t_value;
    end
    rename_hold = rename_valid && !exp_ready;
    fu_hold     = fu_valid & ~exp_grant;
  endtask

  initial begin
    seed         = 32'h389306dc;
    errors       = 0;
    checks       = 0;
    reset        = 1'b1;
    rename_valid = 1'b0;
    rename_req   = '0;
    retire_valid = 1'b0;
    retire_idx   = '0;
    fu_valid     = '0;
    fu_result    = '0;
    fu_read      = '0;
    rename_hold  = 1'b0;
    fu_hold      = '0;
    init_model();
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    for (int c = 0; c < NUM_CYCLES; c++) begin
      drive_inputs();
      @(negedge clock);    // outputs settled
      check_outputs();
      update_model();
      @(posedge clock);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
